/* tb.f */
cpu_pkg.sv
byte_pair_register.sv
alu_unit.sv
cpu_bus.sv
memory.sv
io_ports.sv
cpu.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
RTL_TOP   ?= cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE) -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timescale $(TIMESCALE)
RTL_SRCS  ?= cpu_pkg.sv byte_pair_register.sv alu_unit.sv cpu_bus.sv memory.sv io_ports.sv cpu.sv
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --binary --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* tb_cpu.sv */
module tb_cpu
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Cycles to wait for the compare process before giving up
	localparam int sync_limit = 8;

	// Move test registers with matching source codes
	localparam logic [id_width-1:0] move_regs [10] = '{dst_a, dst_b, dst_r0, dst_r1,
		dst_ir0, dst_ir1, dst_ar0, dst_ar1, dst_sp0, dst_sp1};

	// All defined opcodes plus three undefined ones
	localparam logic [alu_op_width-1:0] alu_ops [11] = '{alu_add, alu_sub, alu_and,
		alu_or, alu_xor, alu_not, alu_shl, alu_shr, 5'd8, 5'd21, 5'd31};

	logic                  clk;
	logic                  rst;
	logic [ctrl_width-1:0] control_bus;
	logic [data_width-1:0] port_a_in, port_b_in, port_c_in, port_d_in;
	logic [data_width-1:0] port_a_out, port_b_out, port_c_out, port_d_out;

	// Shadow of the datapath state
	logic [data_width-1:0] m_a, m_b;
	logic [flag_width-1:0] m_sr;
	logic [addr_width-1:0] m_r1r0, m_ir, m_ar, m_pc, m_sp;
	logic [data_width-1:0] m_port [4];
	logic [data_width-1:0] m_mem [int];
	logic [data_width-1:0] pin [4];

	// Word in flight until its edge has passed
	logic [id_width-1:0]   pend_dst;
	logic [data_width-1:0] pend_bus;
	logic [addr_width-1:0] pend_addr;
	logic                  pend_inc;
	logic                  pend_flag_load;
	logic [flag_width-1:0] pend_flags;

	logic [31:0] lcg_state;
	int err_count, cmp_count, test_pass, test_fail, test_err_start;
	logic [addr_width-1:0] addrs [$];

	cpu u_cpu (
		.clk(clk), .rst(rst), .control_bus(control_bus),
		.port_a_in(port_a_in), .port_b_in(port_b_in),
		.port_c_in(port_c_in), .port_d_in(port_d_in),
		.port_a_out(port_a_out), .port_b_out(port_b_out),
		.port_c_out(port_c_out), .port_d_out(port_d_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[23:16];
	endfunction

	function automatic logic [15:0] rand_word();
		logic [31:0] r;
		r = lcg_next();
		return r[31:16];
	endfunction

	// Flags in the top nibble and result in the low byte
	function automatic logic [11:0] alu_model(input logic [7:0] a, input logic [7:0] b,
			input logic [4:0] op);
		int         sa;
		int         sb;
		logic [7:0] r;
		logic [3:0] f;
		logic       c;
		logic       v;
		sa = $signed(a);
		sb = $signed(b);
		r = a;
		c = 1'b0;
		v = 1'b0;
		case (op)
			alu_add: begin
				r = a + b;
				// Unsigned sum past 255 carries
				c = (int'(a) + int'(b)) > 255;
				// Signed sum outside -128..127
				v = (sa + sb > 127) || (sa + sb < -128);
			end
			alu_sub: begin
				r = a - b;
				// Borrow when A is below B
				c = (a < b);
				v = (sa - sb > 127) || (sa - sb < -128);
			end
			alu_and: r = a & b;
			alu_or:  r = a | b;
			alu_xor: r = a ^ b;
			alu_not: r = ~a;
			alu_shl: begin
				r = {a[6:0], 1'b0};
				c = a[7];
			end
			alu_shr: begin
				r = {1'b0, a[7:1]};
				c = a[0];
			end
			default: r = a;
		endcase
		f = 4'h0;
		f[flag_c] = c;
		f[flag_z] = (r == 8'h00);
		f[flag_n] = r[7];
		f[flag_v] = v;
		return {f, r};
	endfunction

	function automatic logic [15:0] address_select(input logic [1:0] asel);
		case (asel)
			asel_pc:   return m_pc;
			asel_sp:   return m_sp;
			asel_r1r0: return m_r1r0;
			default:   return m_ar;
		endcase
	endfunction

	// Expected data bus value for a source code
	function automatic logic [7:0] bus_source(input logic [4:0] src, input logic [15:0] addr,
			input logic [7:0] alu_res);
		case (src)
			src_a:     return m_a;
			src_b:     return m_b;
			src_r0:    return m_r1r0[7:0];
			src_r1:    return m_r1r0[15:8];
			src_ir0:   return m_ir[7:0];
			src_ir1:   return m_ir[15:8];
			src_porta: return pin[0];
			src_portb: return pin[1];
			src_portc: return pin[2];
			src_portd: return pin[3];
			src_ar0:   return m_ar[7:0];
			src_ar1:   return m_ar[15:8];
			src_pc0:   return m_pc[7:0];
			src_pc1:   return m_pc[15:8];
			src_sp0:   return m_sp[7:0];
			src_sp1:   return m_sp[15:8];
			src_mem: begin
				// Upper half is not RAM
				if (addr[15] || !m_mem.exists(int'(addr[14:0]))) begin
					return 8'h00;
				end
				return m_mem[int'(addr[14:0])];
			end
			src_sr:    return {4'h0, m_sr};
			src_alu:   return alu_res;
			default:   return 8'h00;
		endcase
	endfunction

	function automatic void apply_pending();
		if (pend_flag_load) begin
			m_sr = pend_flags;
		end
		case (pend_dst)
			dst_a:     m_a = pend_bus;
			dst_b:     m_b = pend_bus;
			dst_r0:    m_r1r0[7:0] = pend_bus;
			dst_r1:    m_r1r0[15:8] = pend_bus;
			dst_ir0:   m_ir[7:0] = pend_bus;
			dst_ir1:   m_ir[15:8] = pend_bus;
			dst_porta: m_port[0] = pend_bus;
			dst_portb: m_port[1] = pend_bus;
			dst_portc: m_port[2] = pend_bus;
			dst_portd: m_port[3] = pend_bus;
			dst_ar0:   m_ar[7:0] = pend_bus;
			dst_ar1:   m_ar[15:8] = pend_bus;
			dst_pc0:   m_pc[7:0] = pend_bus;
			dst_pc1:   m_pc[15:8] = pend_bus;
			dst_sp0:   m_sp[7:0] = pend_bus;
			dst_sp1:   m_sp[15:8] = pend_bus;
			dst_mem: begin
				if (!pend_addr[15]) begin
					m_mem[int'(pend_addr[14:0])] = pend_bus;
				end
			end
			default: ;
		endcase
		// Byte write beats the increment
		if (pend_inc && pend_dst != dst_pc0 && pend_dst != dst_pc1) begin
			m_pc = m_pc + 16'd1;
		end
		pend_dst = dst_none;
		pend_inc = 1'b0;
		pend_flag_load = 1'b0;
	endfunction

	// One control word per cycle with pins taken from pin[]
	task automatic issue_word(input logic [4:0] src, input logic [4:0] dst,
			input logic [4:0] op = alu_add, input logic [1:0] asel = asel_ar,
			input logic inc = 1'b0);
		logic [ctrl_width-1:0] word;
		logic [addr_width-1:0] addr;
		logic [11:0]           alu;
		@(posedge clk);
		#5;
		apply_pending();
		// Reserved bits get noise
		word = {lcg_next(), lcg_next()};
		word[alu_op_lsb +: alu_op_width] = op;
		word[src_id_lsb +: id_width] = src;
		word[dst_id_lsb +: id_width] = dst;
		word[addr_src_lsb +: addr_src_width] = asel;
		word[pc_inc_bit] = inc;
		control_bus = word;
		port_a_in = pin[0];
		port_b_in = pin[1];
		port_c_in = pin[2];
		port_d_in = pin[3];
		addr = address_select(asel);
		alu = alu_model(m_a, m_b, op);
		pend_bus = bus_source(src, addr, alu[7:0]);
		pend_dst = dst;
		pend_addr = addr;
		pend_inc = inc;
		pend_flag_load = (src == src_alu);
		pend_flags = alu[11:8];
	endtask

	// Both bytes through port A
	task automatic load_pair(input logic [4:0] dst_lo, input logic [15:0] value);
		pin[0] = value[7:0];
		issue_word(src_porta, dst_lo);
		pin[0] = value[15:8];
		issue_word(src_porta, 5'(dst_lo + 5'd1));
	endtask

	task automatic check_port(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s expected %02h actual %02h at %0t ns",
				name, expected, actual, $time);
			err_count++;
		end
	endtask

	// Compare 10 ns before each edge
	initial begin
		forever begin
			@(posedge clk);
			#90;
			if (!rst) begin
				check_port("port_a_out", port_a_out, m_port[0]);
				check_port("port_b_out", port_b_out, m_port[1]);
				check_port("port_c_out", port_c_out, m_port[2]);
				check_port("port_d_out", port_d_out, m_port[3]);
				cmp_count++;
			end
		end
	end

	task automatic wait_for_compare();
		int target;
		int guard;
		target = cmp_count + 1;
		guard = 0;
		while (cmp_count < target && guard < sync_limit) begin
			@(posedge clk);
			guard++;
		end
		if (cmp_count < target) begin
			$display("ERROR: compare process did not run within %0d cycles", sync_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		issue_word(src_none, dst_none);
		wait_for_compare();
		errs = err_count - test_err_start;
		test_err_start = err_count;
		if (errs == 0) begin
			test_pass++;
			$display("test %s: passed", name);
		end else begin
			test_fail++;
			$display("test %s: failed with %0d mismatches", name, errs);
		end
	endtask

	initial begin
		logic [addr_width-1:0] value16;
		int                    n;
		lcg_state = 32'h79c7c60c;
		rst = 1'b1;
		control_bus = '0;
		port_a_in = '0;
		port_b_in = '0;
		port_c_in = '0;
		port_d_in = '0;
		for (int i = 0; i < 4; i++) begin
			pin[i] = 8'h00;
			m_port[i] = 8'h00;
		end
		{m_a, m_b, m_sr} = '0;
		{m_r1r0, m_ir, m_ar, m_pc, m_sp} = '0;
		{pend_dst, pend_bus, pend_addr, pend_inc, pend_flag_load, pend_flags} = '0;
		{err_count, cmp_count, test_pass, test_fail, test_err_start} = '0;
		repeat (3) @(posedge clk);
		#5;
		rst = 1'b0;

		// Ports and SR zero after reset
		issue_word(src_sr, dst_porta);
		end_test("reset");

		// Load every register from the pins and copy each out
		for (int i = 0; i < 10; i++) begin
			pin[i % 4] = rand_byte();
			issue_word(5'(src_porta + i % 4), move_regs[i]);
		end
		for (int i = 0; i < 10; i++) begin
			issue_word(move_regs[i], 5'(dst_porta + i % 4));
		end
		end_test("moves");

		// Last round uses 80h for both operands
		for (int rnd = 0; rnd < 3; rnd++) begin
			for (int k = 0; k < 11; k++) begin
				pin[0] = (rnd == 2) ? 8'h80 : rand_byte();
				pin[1] = (rnd == 2) ? 8'h80 : rand_byte();
				issue_word(src_porta, dst_a);
				issue_word(src_portb, dst_b);
				issue_word(src_alu, dst_portc, alu_ops[k]);
				issue_word(src_sr, dst_portd);
			end
		end
		end_test("alu");

		addrs.delete();
		repeat (8) begin
			addrs.push_back(rand_word() & 16'h7fff);
		end
		foreach (addrs[i]) begin
			load_pair(dst_ar0, addrs[i]);
			pin[1] = rand_byte();
			issue_word(src_portb, dst_mem, alu_add, asel_ar);
		end
		foreach (addrs[i]) begin
			load_pair(dst_ar0, addrs[i]);
			issue_word(src_mem, dst_porta, alu_add, asel_ar);
		end
		// Write to the upper-half alias of the first cell must not land
		load_pair(dst_r0, addrs[0] | 16'h8000);
		pin[1] = rand_byte();
		issue_word(src_portb, dst_mem, alu_add, asel_r1r0);
		issue_word(src_mem, dst_porta, alu_add, asel_r1r0);
		load_pair(dst_ar0, addrs[0]);
		issue_word(src_mem, dst_porta, alu_add, asel_ar);
		end_test("memory");

		// First round starts near FFFFh so the count wraps
		for (int rnd = 0; rnd < 3; rnd++) begin
			value16 = (rnd == 0) ? 16'hfff0 + 16'(rand_byte() % 16) : rand_word();
			n = 20 + int'(rand_byte() % 40);
			load_pair(dst_pc0, value16);
			repeat (n) begin
				issue_word(src_none, dst_none, alu_add, asel_pc, 1'b1);
			end
			issue_word(src_pc0, dst_porta);
			issue_word(src_pc1, dst_portb);
		end
		// Write and increment in one word
		pin[0] = rand_byte();
		issue_word(src_porta, dst_pc0, alu_add, asel_pc, 1'b1);
		issue_word(src_pc0, dst_portc);
		issue_word(src_pc1, dst_portd);
		end_test("pc");

		for (int rnd = 0; rnd < 4; rnd++) begin
			value16 = rand_word() & 16'h7fff;
			load_pair(dst_sp0, value16);
			pin[2] = rand_byte();
			issue_word(src_portc, dst_mem, alu_add, asel_sp);
			issue_word(src_mem, dst_portd, alu_add, asel_sp);
			// Same cell seen through AR
			load_pair(dst_ar0, value16);
			issue_word(src_mem, dst_porta, alu_add, asel_ar);
		end
		end_test("stack");

		$display("tests passed %0d failed %0d, port checks %0d, mismatches %0d",
			test_pass, test_fail, cmp_count, err_count);
		if (test_fail == 0 && err_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* cpu.sv */
module cpu
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [ctrl_width-1:0] control_bus,
	input  logic [data_width-1:0] port_a_in,
	input  logic [data_width-1:0] port_b_in,
	input  logic [data_width-1:0] port_c_in,
	input  logic [data_width-1:0] port_d_in,
	output logic [data_width-1:0] port_a_out,
	output logic [data_width-1:0] port_b_out,
	output logic [data_width-1:0] port_c_out,
	output logic [data_width-1:0] port_d_out
);

	logic [alu_op_width-1:0]   alu_op;
	logic [id_width-1:0]       src_id;
	logic [id_width-1:0]       dst_id;
	logic [addr_src_width-1:0] addr_src;
	logic                      pc_inc;

	logic [data_width-1:0] data_bus;
	logic [addr_width-1:0] address_bus;

	logic [data_width-1:0] a_value, b_value, alu_result, mem_rdata;
	logic [flag_width-1:0] status;
	logic [addr_width-1:0] r1r0, ir, ar, pc, sp;

	logic we_a, we_b, we_r0, we_r1, we_ir0, we_ir1;
	logic we_porta, we_portb, we_portc, we_portd;
	logic we_ar0, we_ar1, we_pc0, we_pc1, we_sp0, we_sp1;
	logic we_mem, flag_load;

	// Control word fields
	assign alu_op   = control_bus[alu_op_lsb +: alu_op_width];
	assign src_id   = control_bus[src_id_lsb +: id_width];
	assign dst_id   = control_bus[dst_id_lsb +: id_width];
	assign addr_src = control_bus[addr_src_lsb +: addr_src_width];
	assign pc_inc   = control_bus[pc_inc_bit];

	// General pair, can address memory
	byte_pair_register r1r0_pair (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we_r0), .we_hi(we_r1), .cnt_en(1'b0), .value(r1r0)
	);

	// Instruction register, no decoder behind it yet
	byte_pair_register instr_reg (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we_ir0), .we_hi(we_ir1), .cnt_en(1'b0), .value(ir)
	);

	byte_pair_register addr_reg (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we_ar0), .we_hi(we_ar1), .cnt_en(1'b0), .value(ar)
	);

	// Only the PC counts
	byte_pair_register #(.counting(1'b1)) prog_counter (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we_pc0), .we_hi(we_pc1), .cnt_en(pc_inc), .value(pc)
	);

	byte_pair_register stack_ptr (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we_sp0), .we_hi(we_sp1), .cnt_en(1'b0), .value(sp)
	);

	alu_unit u_alu (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_a(we_a), .we_b(we_b), .alu_op(alu_op), .flag_load(flag_load),
		.a_value(a_value), .b_value(b_value), .result(alu_result), .status(status)
	);

	cpu_bus u_bus (
		.src_id(src_id), .dst_id(dst_id), .addr_src(addr_src),
		.a_value(a_value), .b_value(b_value), .alu_result(alu_result), .status(status),
		.port_in_a(port_a_in), .port_in_b(port_b_in),
		.port_in_c(port_c_in), .port_in_d(port_d_in),
		.mem_rdata(mem_rdata),
		.r1r0(r1r0), .ir(ir), .ar(ar), .pc(pc), .sp(sp),
		.data_bus(data_bus), .address_bus(address_bus),
		.we_a(we_a), .we_b(we_b), .we_r0(we_r0), .we_r1(we_r1),
		.we_ir0(we_ir0), .we_ir1(we_ir1),
		.we_porta(we_porta), .we_portb(we_portb),
		.we_portc(we_portc), .we_portd(we_portd),
		.we_ar0(we_ar0), .we_ar1(we_ar1), .we_pc0(we_pc0), .we_pc1(we_pc1),
		.we_sp0(we_sp0), .we_sp1(we_sp1),
		.we_mem(we_mem), .flag_load(flag_load)
	);

	// RAM in the lower half, selected by A15 low
	memory ram (
		.clk(clk), .address(address_bus[mem_addr_width-1:0]),
		.cs(~address_bus[addr_width-1]), .wdata(data_bus),
		.we(we_mem), .rdata(mem_rdata)
	);

	io_ports u_ports (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_porta(we_porta), .we_portb(we_portb),
		.we_portc(we_portc), .we_portd(we_portd),
		.port_a_out(port_a_out), .port_b_out(port_b_out),
		.port_c_out(port_c_out), .port_d_out(port_d_out)
	);

endmodule

/* io_ports.sv */
module io_ports
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [data_width-1:0] data,
	input  logic                  we_porta,
	input  logic                  we_portb,
	input  logic                  we_portc,
	input  logic                  we_portd,
	output logic [data_width-1:0] port_a_out,
	output logic [data_width-1:0] port_b_out,
	output logic [data_width-1:0] port_c_out,
	output logic [data_width-1:0] port_d_out
);

	// Output latches, input pins go straight to the bus mux
	always_ff @(posedge clk) begin
		if (rst) begin
			port_a_out <= '0;
			port_b_out <= '0;
			port_c_out <= '0;
			port_d_out <= '0;
		end else begin
			if (we_porta) begin
				port_a_out <= data;
			end
			if (we_portb) begin
				port_b_out <= data;
			end
			if (we_portc) begin
				port_c_out <= data;
			end
			if (we_portd) begin
				port_d_out <= data;
			end
		end
	end

endmodule

/* memory.sv */
module memory
	import cpu_pkg::*;
(
	input  logic                      clk,
	input  logic [mem_addr_width-1:0] address,
	input  logic                      cs,
	input  logic [data_width-1:0]     wdata,
	input  logic                      we,
	output logic [data_width-1:0]     rdata
);

	logic [data_width-1:0] ram [mem_depth];

	// Asynchronous read, zero when not selected
	assign rdata = cs ? ram[address] : '0;

	// Write at the edge with the address of this cycle
	always_ff @(posedge clk) begin
		if (we && cs) begin
			ram[address] <= wdata;
		end
	end

endmodule

/* cpu_bus.sv */
module cpu_bus
	import cpu_pkg::*;
(
	input  logic [id_width-1:0]       src_id,
	input  logic [id_width-1:0]       dst_id,
	input  logic [addr_src_width-1:0] addr_src,
	// Data bus sources
	input  logic [data_width-1:0]     a_value,
	input  logic [data_width-1:0]     b_value,
	input  logic [data_width-1:0]     alu_result,
	input  logic [flag_width-1:0]     status,
	input  logic [data_width-1:0]     port_in_a,
	input  logic [data_width-1:0]     port_in_b,
	input  logic [data_width-1:0]     port_in_c,
	input  logic [data_width-1:0]     port_in_d,
	input  logic [data_width-1:0]     mem_rdata,
	// Register pairs, also address bus sources
	input  logic [addr_width-1:0]     r1r0,
	input  logic [addr_width-1:0]     ir,
	input  logic [addr_width-1:0]     ar,
	input  logic [addr_width-1:0]     pc,
	input  logic [addr_width-1:0]     sp,
	output logic [data_width-1:0]     data_bus,
	output logic [addr_width-1:0]     address_bus,
	output logic                      we_a,
	output logic                      we_b,
	output logic                      we_r0,
	output logic                      we_r1,
	output logic                      we_ir0,
	output logic                      we_ir1,
	output logic                      we_porta,
	output logic                      we_portb,
	output logic                      we_portc,
	output logic                      we_portd,
	output logic                      we_ar0,
	output logic                      we_ar1,
	output logic                      we_pc0,
	output logic                      we_pc1,
	output logic                      we_sp0,
	output logic                      we_sp1,
	output logic                      we_mem,
	output logic                      flag_load
);

	localparam int lo = data_width;

	logic [dst_mem:0] dst_hot;

	// Data bus source mux, replaces the tri-state drivers
	always_comb begin
		case (src_id)
			src_none:  data_bus = '0;
			src_a:     data_bus = a_value;
			src_b:     data_bus = b_value;
			src_r0:    data_bus = r1r0[lo-1:0];
			src_r1:    data_bus = r1r0[addr_width-1:lo];
			src_ir0:   data_bus = ir[lo-1:0];
			src_ir1:   data_bus = ir[addr_width-1:lo];
			src_porta: data_bus = port_in_a;
			src_portb: data_bus = port_in_b;
			src_portc: data_bus = port_in_c;
			src_portd: data_bus = port_in_d;
			src_ar0:   data_bus = ar[lo-1:0];
			src_ar1:   data_bus = ar[addr_width-1:lo];
			src_pc0:   data_bus = pc[lo-1:0];
			src_pc1:   data_bus = pc[addr_width-1:lo];
			src_sp0:   data_bus = sp[lo-1:0];
			src_sp1:   data_bus = sp[addr_width-1:lo];
			src_mem:   data_bus = mem_rdata;
			// Flags in the low nibble
			src_sr:    data_bus = {{(data_width-flag_width){1'b0}}, status};
			src_alu:   data_bus = alu_result;
			default:   data_bus = '0;
		endcase
	end

	// Address bus source mux
	always_comb begin
		case (addr_src)
			asel_ar:   address_bus = ar;
			asel_pc:   address_bus = pc;
			asel_sp:   address_bus = sp;
			asel_r1r0: address_bus = r1r0;
			default:   address_bus = ar;
		endcase
	end

	// One-hot destination decode
	always_comb begin
		dst_hot = '0;
		if (dst_id != dst_none && dst_id <= dst_mem) begin
			dst_hot[dst_id] = 1'b1;
		end
	end

	assign we_a      = dst_hot[dst_a];
	assign we_b      = dst_hot[dst_b];
	assign we_r0     = dst_hot[dst_r0];
	assign we_r1     = dst_hot[dst_r1];
	assign we_ir0    = dst_hot[dst_ir0];
	assign we_ir1    = dst_hot[dst_ir1];
	assign we_porta  = dst_hot[dst_porta];
	assign we_portb  = dst_hot[dst_portb];
	assign we_portc  = dst_hot[dst_portc];
	assign we_portd  = dst_hot[dst_portd];
	assign we_ar0    = dst_hot[dst_ar0];
	assign we_ar1    = dst_hot[dst_ar1];
	assign we_pc0    = dst_hot[dst_pc0];
	assign we_pc1    = dst_hot[dst_pc1];
	assign we_sp0    = dst_hot[dst_sp0];
	assign we_sp1    = dst_hot[dst_sp1];
	assign we_mem    = dst_hot[dst_mem];

	// Status follows every ALU transfer
	assign flag_load = (src_id == src_alu);

endmodule

/* alu_unit.sv */
module alu_unit
	import cpu_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [data_width-1:0]   data,
	input  logic                    we_a,
	input  logic                    we_b,
	input  logic [alu_op_width-1:0] alu_op,
	input  logic                    flag_load,
	output logic [data_width-1:0]   a_value,
	output logic [data_width-1:0]   b_value,
	output logic [data_width-1:0]   result,
	output logic [flag_width-1:0]   status
);

	logic [data_width:0]   wide;
	logic                  carry;
	logic                  overflow;
	logic [flag_width-1:0] flags;

	// Accumulator and B register
	always_ff @(posedge clk) begin
		if (rst) begin
			a_value <= '0;
			b_value <= '0;
		end else begin
			if (we_a) begin
				a_value <= data;
			end
			if (we_b) begin
				b_value <= data;
			end
		end
	end

	// Result with carry and overflow
	always_comb begin
		wide     = '0;
		result   = a_value;
		carry    = 1'b0;
		overflow = 1'b0;
		case (alu_op)
			alu_add: begin
				wide     = {1'b0, a_value} + {1'b0, b_value};
				result   = wide[data_width-1:0];
				carry    = wide[data_width];
				// Same-sign operands giving a different-sign sum
				overflow = (a_value[data_width-1] == b_value[data_width-1]) &&
					(result[data_width-1] != a_value[data_width-1]);
			end
			alu_sub: begin
				// Top bit of the extended difference is the borrow
				wide     = {1'b0, a_value} - {1'b0, b_value};
				result   = wide[data_width-1:0];
				carry    = wide[data_width];
				overflow = (a_value[data_width-1] != b_value[data_width-1]) &&
					(result[data_width-1] != a_value[data_width-1]);
			end
			alu_and: result = a_value & b_value;
			alu_or:  result = a_value | b_value;
			alu_xor: result = a_value ^ b_value;
			alu_not: result = ~a_value;
			alu_shl: begin
				result = {a_value[data_width-2:0], 1'b0};
				carry  = a_value[data_width-1];
			end
			alu_shr: begin
				result = {1'b0, a_value[data_width-1:1]};
				carry  = a_value[0];
			end
			// Undefined codes pass A
			default: result = a_value;
		endcase
	end

	// New flags from the current result
	always_comb begin
		flags         = '0;
		flags[flag_c] = carry;
		flags[flag_z] = (result == '0);
		flags[flag_n] = result[data_width-1];
		flags[flag_v] = overflow;
	end

	// Status register, loaded when the ALU drives the bus
	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else if (flag_load) begin
			status <= flags;
		end
	end

endmodule

/* byte_pair_register.sv */
module byte_pair_register
	import cpu_pkg::*;
#(
	// Set only for the program counter
	parameter bit counting = 1'b0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [data_width-1:0] data,
	input  logic                  we_lo,
	input  logic                  we_hi,
	input  logic                  cnt_en,
	output logic [addr_width-1:0] value
);

	logic byte_write;

	// Any byte write blocks the increment for this cycle
	assign byte_write = we_lo | we_hi;

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= '0;
		end else if (byte_write) begin
			// Low and high byte may load together from the same bus value
			if (we_lo) begin
				value[data_width-1:0] <= data;
			end
			if (we_hi) begin
				value[addr_width-1:data_width] <= data;
			end
		end else if (counting && cnt_en) begin
			// Wraps from FFFFh to 0000h
			value <= value + 1'b1;
		end
	end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

	// Bus and word widths
	localparam int data_width     = 8;
	localparam int addr_width     = 16;
	localparam int ctrl_width     = 64;
	localparam int flag_width     = 4;
	localparam int mem_depth      = 32768;
	localparam int mem_addr_width = $clog2(mem_depth);

	// Control word layout, bits above pc_inc_bit are reserved
	localparam int alu_op_lsb     = 0;
	localparam int alu_op_width   = 5;
	localparam int src_id_lsb     = 5;
	localparam int dst_id_lsb     = 10;
	localparam int id_width       = 5;
	localparam int addr_src_lsb   = 15;
	localparam int addr_src_width = 2;
	localparam int pc_inc_bit     = 17;

	// Data bus sources
	localparam logic [id_width-1:0] src_none  = 5'd0;
	localparam logic [id_width-1:0] src_a     = 5'd1;
	localparam logic [id_width-1:0] src_b     = 5'd2;
	localparam logic [id_width-1:0] src_r0    = 5'd3;
	localparam logic [id_width-1:0] src_r1    = 5'd4;
	localparam logic [id_width-1:0] src_ir0   = 5'd5;
	localparam logic [id_width-1:0] src_ir1   = 5'd6;
	localparam logic [id_width-1:0] src_porta = 5'd7;
	localparam logic [id_width-1:0] src_portb = 5'd8;
	localparam logic [id_width-1:0] src_portc = 5'd9;
	localparam logic [id_width-1:0] src_portd = 5'd10;
	localparam logic [id_width-1:0] src_ar0   = 5'd11;
	localparam logic [id_width-1:0] src_ar1   = 5'd12;
	localparam logic [id_width-1:0] src_pc0   = 5'd13;
	localparam logic [id_width-1:0] src_pc1   = 5'd14;
	localparam logic [id_width-1:0] src_sp0   = 5'd15;
	localparam logic [id_width-1:0] src_sp1   = 5'd16;
	localparam logic [id_width-1:0] src_mem   = 5'd17;
	localparam logic [id_width-1:0] src_sr    = 5'd18;
	localparam logic [id_width-1:0] src_alu   = 5'd19;

	// Data bus destinations, 18 and up write nothing
	localparam logic [id_width-1:0] dst_none  = 5'd0;
	localparam logic [id_width-1:0] dst_a     = 5'd1;
	localparam logic [id_width-1:0] dst_b     = 5'd2;
	localparam logic [id_width-1:0] dst_r0    = 5'd3;
	localparam logic [id_width-1:0] dst_r1    = 5'd4;
	localparam logic [id_width-1:0] dst_ir0   = 5'd5;
	localparam logic [id_width-1:0] dst_ir1   = 5'd6;
	localparam logic [id_width-1:0] dst_porta = 5'd7;
	localparam logic [id_width-1:0] dst_portb = 5'd8;
	localparam logic [id_width-1:0] dst_portc = 5'd9;
	localparam logic [id_width-1:0] dst_portd = 5'd10;
	localparam logic [id_width-1:0] dst_ar0   = 5'd11;
	localparam logic [id_width-1:0] dst_ar1   = 5'd12;
	localparam logic [id_width-1:0] dst_pc0   = 5'd13;
	localparam logic [id_width-1:0] dst_pc1   = 5'd14;
	localparam logic [id_width-1:0] dst_sp0   = 5'd15;
	localparam logic [id_width-1:0] dst_sp1   = 5'd16;
	localparam logic [id_width-1:0] dst_mem   = 5'd17;

	// Address bus sources
	localparam logic [addr_src_width-1:0] asel_ar   = 2'd0;
	localparam logic [addr_src_width-1:0] asel_pc   = 2'd1;
	localparam logic [addr_src_width-1:0] asel_sp   = 2'd2;
	localparam logic [addr_src_width-1:0] asel_r1r0 = 2'd3;

	// ALU operations
	localparam logic [alu_op_width-1:0] alu_add = 5'd0;
	localparam logic [alu_op_width-1:0] alu_sub = 5'd1;
	localparam logic [alu_op_width-1:0] alu_and = 5'd2;
	localparam logic [alu_op_width-1:0] alu_or  = 5'd3;
	localparam logic [alu_op_width-1:0] alu_xor = 5'd4;
	localparam logic [alu_op_width-1:0] alu_not = 5'd5;
	localparam logic [alu_op_width-1:0] alu_shl = 5'd6;
	localparam logic [alu_op_width-1:0] alu_shr = 5'd7;

	// Status bits
	localparam int flag_c = 0;
	localparam int flag_z = 1;
	localparam int flag_n = 2;
	localparam int flag_v = 3;

endpackage
